/* dc2390_scope.f */
+incdir+source
source/dc2390_scope_pkg.sv
source/sample_timer.sv
source/trigger_ctrl.sv
source/lut_player.sv
source/dac_output.sv
source/capture_buffer.sv
source/dc2390_scope.sv
verif/dc2390_scope_asserts.sv
verif/dc2390_scope_tb.sv

/* verif/dc2390_scope_golden.txt */
// id clocks_per_sample num_samples ctrl_a ctrl_b exp0 exp1 exp2, all hex
// ctrl = DAC select or capture source code; exp = expected words, or stimulus where noted
1 3 0  2 3 C000 4000     0
2 3 0  2 1 1234 9234     C000
3 3 8  2 0 8    1        FFFF
4 3 C  0 0 C    A5000000 0
5 1 14 3 0 10   DEADBEEF 1

/* verif/dc2390_scope_tb.sv */
`include "dc2390_scope_settings.svh"

module dc2390_scope_tb import dc2390_scope_pkg::*;
();

    localparam int ROWS = 5;                            // Tests in the golden file
    localparam int COLS = 8;                            // Words per test

    logic adc_clk, reset, force_trig, trig_in, arm, capture_busy, run_once;
    logic lut_wr_en, adc_a_valid, adc_b_valid, cap_valid, cap_ready, overflow;
    logic [`TICK_W-1:0]  clocks_per_sample;
    logic [`NSAMP_W-1:0] num_samples;
    logic [`DAC_W-1:0]   dac_a, dac_b;
    lut_mode_t  lut_mode;
    lut_addr_t  lut_wr_addr;
    dac_word_t  lut_wr_data;
    dac_sel_t   dac_a_select, dac_b_select;
    cap_src_t   capture_src;
    cap_word_t  adc_a_data, adc_b_data, cap_data, adc_base;

    logic [31:0] gold [ROWS*COLS];                      // Golden file image
    cap_word_t   got_q [$];                             // Words taken from the stream
    cap_word_t   exp_q [$];                             // ADC words strobed in the window
    logic [15:0] lfsr = 16'd38321;
    logic [1:0]  ready_mode;                            // 0 low, 1 high, 2 random
    logic        strobe_rand;                           // Random ADC strobes
    int strobe_cnt, errors, checks, cycles;
    int limit = 100000;

    dc2390_scope i_dut (.*);

    initial
    begin
        adc_clk = 1'b0;
        forever #20 adc_clk = ~adc_clk;                 // Period 40
    end

    initial
    begin
        cycles = 0;
        while (cycles <= limit)
        begin
            @(posedge adc_clk);
            cycles++;
        end
        $display("Timeout: run still going after %0d cycles", limit);
        $display("TEST FAIL");
        $finish;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic lfsr_bit();
        logic b;
        b    = lfsr[0];
        lfsr = (lfsr >> 1) ^ (b ? 16'hB400 : 16'h0000);
        return b;
    endfunction

    function automatic dac_word_t fill_word(input lut_addr_t a);
        return {a, ~a};                                 // Distinct per entry
    endfunction

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // One clock: sample the stream, then drive ready and the ADC strobes
    task automatic run_cycle();
        logic rdy;
        logic stb;
        @(negedge adc_clk);
        rdy = (ready_mode == 2'd2) ? lfsr_bit() : ready_mode[0];
        stb = strobe_rand ? lfsr_bit() : 1'b0;
        if (cap_valid && rdy)
            got_q.push_back(cap_data);                  // Transfers on next rising edge
        cap_ready   = rdy;
        adc_a_data  = adc_base + strobe_cnt;
        adc_b_data  = ~adc_a_data;
        adc_a_valid = stb;
        adc_b_valid = stb;
        if (stb && capture_busy && capture_src == CAP_ADC_A)
            exp_q.push_back(adc_a_data);                // Window is open at the next edge
        if (stb)
            strobe_cnt++;
    endtask

    task automatic open_window();
        force_trig = 1'b1;
        while (!capture_busy)
            run_cycle();
        force_trig = 1'b0;
    endtask

    // **********************************************************************
    // Test sequence
    initial
    begin
        int b;
        int err_before;
        $readmemh("verif/dc2390_scope_golden.txt", gold);
        limit = 2000;                                   // Margin for reset and table fill
        for (int t = 0; t < ROWS; t++)
            limit += (gold[t*COLS+2] + 16) * (gold[t*COLS+1] + 1) * 4;
        {reset, force_trig, trig_in, arm, run_once, lut_wr_en} = 6'b100100;
        {adc_a_valid, adc_b_valid, cap_ready, ready_mode, strobe_rand} = '0;
        {lut_wr_addr, lut_wr_data, adc_a_data, adc_b_data, adc_base, strobe_cnt} = '0;
        lut_mode          = LUT_SEQ;
        dac_a_select      = SEL_PATTERN;
        dac_b_select      = SEL_PATTERN;
        capture_src       = CAP_ADC_A;
        clocks_per_sample = gold[1][`TICK_W-1:0];
        num_samples       = '0;
        repeat (10) @(negedge adc_clk);
        reset = 1'b0;
        for (int t = 0; t < ROWS; t++)
        begin
            b          = t * COLS;
            err_before = errors;
            got_q.delete();
            exp_q.delete();
            clocks_per_sample = gold[b+1][`TICK_W-1:0];
            num_samples       = gold[b+2][`NSAMP_W-1:0];
            case (gold[b])
                1:                                      // Constant levels, then swapped
                begin
                    dac_a_select = dac_sel_t'(gold[b+3][1:0]);
                    dac_b_select = dac_sel_t'(gold[b+4][1:0]);
                    repeat (2) run_cycle();
                    expect_equal("dac_a", dac_a, gold[b+5]);
                    expect_equal("dac_b", dac_b, gold[b+6]);
                    dac_a_select = dac_sel_t'(gold[b+4][1:0]);
                    dac_b_select = dac_sel_t'(gold[b+3][1:0]);
                    repeat (2) run_cycle();
                    expect_equal("dac_a swapped", dac_a, gold[b+6]);
                    expect_equal("dac_b swapped", dac_b, gold[b+5]);
                end
                2:                                      // Correction path through the table
                begin
                    for (int a = 0; a < 256; a++)
                    begin
                        lut_wr_en   = 1'b1;
                        lut_wr_addr = lut_addr_t'(a);
                        lut_wr_data = (a == 'h40) ? gold[b+5][15:0] : fill_word(lut_addr_t'(a));
                        run_cycle();
                    end
                    lut_wr_en    = 1'b0;
                    lut_mode     = LUT_CORRECT;
                    dac_a_select = dac_sel_t'(gold[b+3][1:0]);
                    dac_b_select = dac_sel_t'(gold[b+4][1:0]);
                    repeat (6) run_cycle();             // Selector, table, selector, output
                    expect_equal("dac_b from table", dac_b, gold[b+6]);
                    expect_equal("dac_a", dac_a, gold[b+7]);
                end
                3:                                      // Pattern words, ready held high
                begin
                    capture_src = cap_src_t'(gold[b+3][1:0]);
                    ready_mode  = 2'd1;
                    open_window();
                    while (capture_busy)
                        run_cycle();
                    while (cap_valid)
                        run_cycle();                    // Drain what the FIFO still holds
                    expect_equal("pattern word count", got_q.size(), gold[b+5]);
                    for (int i = 1; i < got_q.size(); i++)
                    begin
                        expect_equal("up half", got_q[i][31:16],
                                     16'(got_q[i-1][31:16] + gold[b+6][15:0]));
                        expect_equal("down half", got_q[i][15:0],
                                     16'(got_q[i-1][15:0] + gold[b+7][15:0]));
                    end
                end
                4:                                      // ADC A, random strobes and ready
                begin
                    capture_src = cap_src_t'(gold[b+3][1:0]);
                    ready_mode  = 2'd2;
                    strobe_rand = 1'b1;
                    adc_base    = gold[b+6];
                    strobe_cnt  = 0;
                    open_window();
                    while (capture_busy)
                        run_cycle();
                    while (cap_valid)
                        run_cycle();
                    expect_equal("strobed word count", exp_q.size(), gold[b+5]);
                    expect_equal("stream word count", got_q.size(), gold[b+5]);
                    for (int i = 0; i < got_q.size(); i++)
                        expect_equal("adc_a word", got_q[i], exp_q[i]);
                    strobe_rand = 1'b0;
                    ready_mode  = 2'd1;
                    run_cycle();
                end
                default:                                // Marker into a stalled FIFO
                begin
                    capture_src = cap_src_t'(gold[b+3][1:0]);
                    ready_mode  = 2'd0;
                    open_window();
                    while (!overflow)
                        run_cycle();
                    capture_src = CAP_ADC_B;            // No strobes, window stays open
                    ready_mode  = 2'd1;
                    while (cap_valid)
                        run_cycle();
                    expect_equal("drained word count", got_q.size(), gold[b+5]);
                    foreach (got_q[i])
                        expect_equal("marker word", got_q[i], gold[b+6]);
                    expect_equal("capture_busy", capture_busy, gold[b+7]);
                end
            endcase
            $display("Test %0d done, %0d errors", gold[b], errors - err_before);
        end
        errors += i_dut.i_asserts.fail_count;
        $display("Checks run %0d, failed %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* verif/dc2390_scope_asserts.sv */
module dc2390_scope_asserts import dc2390_scope_pkg::*;
(
    input  logic        adc_clk,
    input  logic        reset,
    input  cap_word_t   cap_data,
    input  logic        cap_valid,
    input  logic        cap_ready,
    input  logic        overflow,
    input  logic        capture_busy
);

    int fail_count = 0;                                 // Failed properties so far

    // **********************************************************************
    // Stream, overflow and reset properties
    hold_data: assert property (@(posedge adc_clk) disable iff (reset)
                                (cap_valid && !cap_ready) |=> $stable(cap_data))
    else
    begin
        $error("cap_data changed while the word was stalled");
        fail_count++;
    end

    sticky_overflow: assert property (@(posedge adc_clk) disable iff (reset)
                                      overflow |=> overflow)
    else
    begin
        $error("overflow fell without a reset");
        fail_count++;
    end

    idle_in_reset: assert property (@(posedge adc_clk) reset |-> !capture_busy)
    else
    begin
        $error("capture_busy high during reset");
        fail_count++;
    end

endmodule

bind dc2390_scope dc2390_scope_asserts i_asserts (.adc_clk, .reset, .cap_data, .cap_valid,
                                                  .cap_ready, .overflow, .capture_busy);

/* source/dc2390_scope.sv */
`include "dc2390_scope_settings.svh"

module dc2390_scope import dc2390_scope_pkg::*;
(
    input  logic                adc_clk,
    input  logic                reset,
    // Sample rate and trigger
    input  logic [`TICK_W-1:0]  clocks_per_sample,
    input  logic                force_trig,
    input  logic                trig_in,
    input  logic                arm,
    input  logic [`NSAMP_W-1:0] num_samples,
    output logic                capture_busy,
    // Lookup table
    input  logic                run_once,
    input  lut_mode_t           lut_mode,
    input  logic                lut_wr_en,
    input  lut_addr_t           lut_wr_addr,
    input  dac_word_t           lut_wr_data,
    // DAC and capture control
    input  dac_sel_t            dac_a_select,
    input  dac_sel_t            dac_b_select,
    input  cap_src_t            capture_src,
    // Parallel ADC words
    input  cap_word_t           adc_a_data,
    input  logic                adc_a_valid,
    input  cap_word_t           adc_b_data,
    input  logic                adc_b_valid,
    // Capture stream
    output cap_word_t           cap_data,
    output logic                cap_valid,
    input  logic                cap_ready,
    output logic                overflow,
    // DAC outputs, offset binary
    output logic [`DAC_W-1:0]   dac_a,
    output logic [`DAC_W-1:0]   dac_b
);

    logic       sample_tick;
    cap_word_t  pattern_word;
    logic       trig_pulse;
    logic       capture_active;
    logic       sample_taken;
    dac_word_t  lut_data;
    dac_word_t  dac_a_signed;       // Loops back as correction address

    assign capture_busy = capture_active;

    // **********************************************************************
    // Timing and trigger
    sample_timer i_sample_timer (.adc_clk, .reset, .clocks_per_sample, .sample_tick,
                                 .pattern_word);

    trigger_ctrl i_trigger_ctrl (.adc_clk, .reset, .force_trig, .trig_in, .arm,
                                 .num_samples, .sample_taken, .trig_pulse, .capture_active);

    // **********************************************************************
    // DAC path
    lut_player i_lut_player (.adc_clk, .reset, .lut_mode, .run_once, .trig_pulse,
                             .dac_a_signed, .wr_en(lut_wr_en), .wr_addr(lut_wr_addr),
                             .wr_data(lut_wr_data), .lut_data);

    dac_output i_dac_output (.adc_clk, .reset, .dac_a_select, .dac_b_select, .pattern_word,
                             .lut_data, .dac_a_signed, .dac_a, .dac_b);

    // **********************************************************************
    // Capture path
    capture_buffer i_capture_buffer (.adc_clk, .reset, .capture_src, .capture_active,
                                     .adc_a_data, .adc_a_valid, .adc_b_data, .adc_b_valid,
                                     .pattern_word, .sample_tick, .sample_taken, .cap_data,
                                     .cap_valid, .cap_ready, .overflow);

endmodule

/* source/capture_buffer.sv */
`include "dc2390_scope_settings.svh"

module capture_buffer import dc2390_scope_pkg::*;
(
    input  logic        adc_clk,
    input  logic        reset,
    input  cap_src_t    capture_src,        // Which word goes to the FIFO
    input  logic        capture_active,     // Window from trigger block
    input  cap_word_t   adc_a_data,
    input  logic        adc_a_valid,
    input  cap_word_t   adc_b_data,
    input  logic        adc_b_valid,
    input  cap_word_t   pattern_word,
    input  logic        sample_tick,
    output logic        sample_taken,       // Word stored this cycle
    output cap_word_t   cap_data,           // Stream out, show-ahead
    output logic        cap_valid,
    input  logic        cap_ready,
    output logic        overflow            // Sticky, word dropped on full
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

    cap_word_t          fifo_mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   fill_cnt;           // Words held
    cap_word_t          src_data;
    logic               src_valid;
    logic               wr_req;             // Gated source strobe
    logic               wr_en;
    logic               rd_en;
    logic               fifo_full;

    // **********************************************************************
    // Source select
    always_comb
    begin
        case (capture_src)
            CAP_ADC_A:   src_data = adc_a_data;
            CAP_ADC_B:   src_data = adc_b_data;
            CAP_PATTERN: src_data = pattern_word;
            default:     src_data = `CAP_MARKER;
        endcase
        case (capture_src)
            CAP_ADC_A:   src_valid = adc_a_valid;
            CAP_ADC_B:   src_valid = adc_b_valid;
            default:     src_valid = sample_tick;   // Pattern and marker on tick
        endcase
    end

    assign wr_req       = src_valid & capture_active;     // Only inside the window
    assign fifo_full    = (fill_cnt == CNT_W'(`FIFO_DEPTH));
    assign wr_en        = wr_req & ~fifo_full;
    assign sample_taken = wr_en;                            // Dropped words do not count
    assign cap_valid    = (fill_cnt != '0);
    assign rd_en        = cap_valid & cap_ready;            // Transfer cycle
    assign cap_data     = fifo_mem[rd_ptr];                 // Head word, held until read

    // **********************************************************************
    // FIFO storage and pointers
    always_ff @(posedge adc_clk)
    begin
        if (wr_en)
            fifo_mem[wr_ptr] <= src_data;
    end

    always_ff @(posedge adc_clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill_cnt <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at depth
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   fill_cnt <= fill_cnt + 1'b1;
                2'b01:   fill_cnt <= fill_cnt - 1'b1;
                default: fill_cnt <= fill_cnt;
            endcase
            if (wr_req && fifo_full)
                overflow <= 1'b1;           // Held until reset
        end
    end

endmodule

/* source/dac_output.sv */
`include "dc2390_scope_settings.svh"

module dac_output import dc2390_scope_pkg::*;
(
    input  logic                adc_clk,
    input  logic                reset,
    input  dac_sel_t            dac_a_select,
    input  dac_sel_t            dac_b_select,
    input  cap_word_t           pattern_word,   // {up, down} test counters
    input  dac_word_t           lut_data,
    output dac_word_t           dac_a_signed,   // Selector output, also to table
    output logic [`DAC_W-1:0]   dac_a,          // Offset binary to converter
    output logic [`DAC_W-1:0]   dac_b
);

    dac_word_t dac_b_signed;

    // Four-way source pick shared by both channels
    function automatic dac_word_t pick_source(input dac_sel_t sel, input dac_word_t pat,
                                              input dac_word_t lut);
        dac_word_t res;
        case (sel)
            SEL_PATTERN: res = pat;
            SEL_LUT:     res = lut;
            SEL_POS:     res = `DAC_POS_LEVEL;
            default:     res = `DAC_NEG_LEVEL;
        endcase
        return res;
    endfunction

    // **********************************************************************
    // Selector registers, then two's complement to offset binary
    always_ff @(posedge adc_clk or posedge reset)
    begin
        if (reset)
        begin
            dac_a_signed <= '0;
            dac_b_signed <= '0;
            dac_a        <= `DAC_OFFSET_ZERO;       // Mid-scale out of reset
            dac_b        <= `DAC_OFFSET_ZERO;
        end
        else
        begin
            dac_a_signed <= pick_source(dac_a_select, pattern_word[`CAP_W-1 -: `DAC_W], lut_data);
            dac_b_signed <= pick_source(dac_b_select, pattern_word[`DAC_W-1:0], lut_data);
            dac_a        <= {~dac_a_signed[`DAC_W-1], dac_a_signed[`DAC_W-2:0]};  // Flip sign
            dac_b        <= {~dac_b_signed[`DAC_W-1], dac_b_signed[`DAC_W-2:0]};
        end
    end

endmodule

/* source/lut_player.sv */
`include "dc2390_scope_settings.svh"

module lut_player import dc2390_scope_pkg::*;
(
    input  logic        adc_clk,
    input  logic        reset,
    input  lut_mode_t   lut_mode,           // Counter or distortion correction
    input  logic        run_once,           // Stop after one pass through table
    input  logic        trig_pulse,         // Restarts a stopped pass
    input  dac_word_t   dac_a_signed,       // Channel A word for correction mode
    input  logic        wr_en,              // Table write port
    input  lut_addr_t   wr_addr,
    input  dac_word_t   wr_data,
    output dac_word_t   lut_data            // Registered table output
);

    localparam int LUT_DEPTH = 1 << `LUT_AW;

    dac_word_t  lut_mem [LUT_DEPTH];        // Table storage
    lut_addr_t  addr_cnt;                   // Sequencing counter
    lut_addr_t  rd_addr;                    // Selected read address
    logic       stopped;                    // Run-once pass finished
    logic       cnt_en;

    // **********************************************************************
    // Address counter with run-once gating
    assign cnt_en = !run_once || !stopped || trig_pulse;

    always_ff @(posedge adc_clk or posedge reset)
    begin
        if (reset)
        begin
            addr_cnt <= '0;
            stopped  <= 1'b0;
        end
        else
        begin
            if (cnt_en)
                addr_cnt <= addr_cnt + 1'b1;
            if (!run_once || trig_pulse)
                stopped <= 1'b0;            // Free run or restart
            else if (cnt_en && (addr_cnt == '1))
                stopped <= 1'b1;            // Parks at zero after the wrap
        end
    end

    // Correction mode indexes by the top bits of channel A
    assign rd_addr = (lut_mode == LUT_CORRECT) ? dac_a_signed[`DAC_W-1 -: `LUT_AW]
                                               : addr_cnt;

    // **********************************************************************
    // Table memory, synchronous write, registered read
    always_ff @(posedge adc_clk)
    begin
        if (wr_en)
            lut_mem[wr_addr] <= wr_data;
    end

    always_ff @(posedge adc_clk)
    begin
        lut_data <= lut_mem[rd_addr];       // One cycle from address
    end

endmodule

/* source/trigger_ctrl.sv */
`include "dc2390_scope_settings.svh"

module trigger_ctrl
(
    input  logic                    adc_clk,
    input  logic                    reset,
    input  logic                    force_trig,     // Asynchronous, from software
    input  logic                    trig_in,        // External, already synchronous
    input  logic                    arm,            // Level, enables a new capture
    input  logic [`NSAMP_W-1:0]     num_samples,    // Words per capture
    input  logic                    sample_taken,   // One pulse per word stored
    output logic                    trig_pulse,     // Rising edge of either trigger
    output logic                    capture_active  // Capture window
);

    logic                   ft_1;                   // Synchronizer stages
    logic                   ft_2;
    logic                   ft_3;
    logic                   trig_any;               // Merged trigger level
    logic                   trig_old;               // Last cycle's trigger level
    logic [`NSAMP_W-1:0]    taken_cnt;              // Words taken this capture
    logic [`NSAMP_W-1:0]    taken_next;

    // **********************************************************************
    // Three-stage synchronizer for the forced trigger
    always_ff @(posedge adc_clk or posedge reset)
    begin
        if (reset)
        begin
            ft_1     <= 1'b0;
            ft_2     <= 1'b0;
            ft_3     <= 1'b0;
            trig_old <= 1'b0;
        end
        else
        begin
            ft_1     <= force_trig;
            ft_2     <= ft_1;
            ft_3     <= ft_2;
            trig_old <= trig_any;                   // Edge detector history
        end
    end

    assign trig_any   = ft_3 | trig_in;
    assign trig_pulse = trig_any & ~trig_old;       // Single-cycle rising edge

    // **********************************************************************
    // Capture window
    // Closes on the same edge that stores the last word, so no extra
    // word can slip in
    assign taken_next = taken_cnt + 1'b1;

    always_ff @(posedge adc_clk or posedge reset)
    begin
        if (reset)
        begin
            capture_active <= 1'b0;
            taken_cnt      <= '0;
        end
        else if (!capture_active)
        begin
            if (trig_pulse && arm && (num_samples != '0))
            begin
                capture_active <= 1'b1;             // Open on armed edge
                taken_cnt      <= '0;
            end
        end
        else if (sample_taken)
        begin
            taken_cnt <= taken_next;
            if (taken_next >= num_samples)
                capture_active <= 1'b0;             // Last word stored
        end
    end

endmodule

/* source/sample_timer.sv */
`include "dc2390_scope_settings.svh"

module sample_timer import dc2390_scope_pkg::*;
(
    input  logic                adc_clk,
    input  logic                reset,
    input  logic [`TICK_W-1:0]  clocks_per_sample,  // Tick spacing minus one
    output logic                sample_tick,        // One cycle per sample period
    output cap_word_t           pattern_word        // {up count, down count}
);

    logic [`TICK_W-1:0]     period_cnt;             // Cycles left to next tick
    logic [`PAT_HALF_W-1:0] count_up;               // Steps +1 per tick
    logic [`PAT_HALF_W-1:0] count_down;             // Steps -1 per tick

    // **********************************************************************
    // Period counter and pattern counters
    // Counters step on the same edge as the tick, so the tick
    // cycle already carries the new pattern value
    always_ff @(posedge adc_clk or posedge reset)
    begin
        if (reset)
        begin
            period_cnt  <= clocks_per_sample;       // Start a full period
            sample_tick <= 1'b0;
            count_up    <= '0;
            count_down  <= '0;
        end
        else if (period_cnt == '0)
        begin
            period_cnt  <= clocks_per_sample;       // Reload
            sample_tick <= 1'b1;
            count_up    <= count_up + 1'b1;
            count_down  <= count_down - 1'b1;
        end
        else
        begin
            period_cnt  <= period_cnt - 1'b1;
            sample_tick <= 1'b0;
        end
    end

    assign pattern_word = {count_up, count_down};  // Up half on top

endmodule

/* source/dc2390_scope_pkg.sv */
`include "dc2390_scope_settings.svh"

package dc2390_scope_pkg;

    // **********************************************************************
    // Payload types
    typedef logic signed [`DAC_W-1:0]  dac_word_t;     // Signed DAC sample
    typedef logic        [`CAP_W-1:0]  cap_word_t;     // Capture word
    typedef logic        [`LUT_AW-1:0] lut_addr_t;     // Table address

    // **********************************************************************
    // Control encodings
    typedef enum logic [1:0]
    {
        SEL_PATTERN = 2'd0,     // Pattern half, upper for A, lower for B
        SEL_LUT     = 2'd1,     // Table output
        SEL_POS     = 2'd2,     // Positive level
        SEL_NEG     = 2'd3      // Negative level
    } dac_sel_t;

    typedef enum logic [1:0]
    {
        CAP_ADC_A      = 2'd0,  // ADC A word on its strobe
        CAP_ADC_B      = 2'd1,  // ADC B word on its strobe
        CAP_PATTERN    = 2'd2,  // Up/down counters on sample tick
        CAP_MARKER_SRC = 2'd3   // Fixed marker on sample tick
    } cap_src_t;

    typedef enum logic
    {
        LUT_SEQ     = 1'b0,     // Address from counter
        LUT_CORRECT = 1'b1      // Address from channel A word
    } lut_mode_t;

endpackage

/* source/dc2390_scope_settings.svh */
`ifndef DC2390_SCOPE_SETTINGS_SVH
`define DC2390_SCOPE_SETTINGS_SVH

// **********************************************************************
// Datapath widths
`define DAC_W           16              // DAC word, two's complement inside
`define CAP_W           32              // Capture stream word
`define LUT_AW          8               // Table address, 256 entries
`define TICK_W          24              // Sample period counter
`define NSAMP_W         30              // Samples per capture

// **********************************************************************
// Buffer depth
`define FIFO_DEPTH      16              // Capture FIFO entries, power of two

// **********************************************************************
// Fixed levels and markers
`define DAC_POS_LEVEL   16'h4000        // Plus half scale
`define DAC_NEG_LEVEL   16'hC000        // Minus half scale
`define DAC_OFFSET_ZERO 16'h8000        // Mid-scale in offset binary
`define CAP_MARKER      32'hDEADBEEF    // Simple known capture word

// Pattern word holds two DAC-wide halves
`define PAT_HALF_W      (`CAP_W / 2)

`endif
